//--- logic/acc_mem_pkg.sv
package acc_mem_pkg;

    // data path and memory word
    parameter int WORD_W = 16;

    // one word per address, 2048 words max
    parameter int ADDR_W = 11;

    // data or instruction word
    typedef logic [WORD_W-1:0] word_t;

    // main memory address
    typedef logic [ADDR_W-1:0] addr_t;

endpackage

//--- logic/acc_isa_pkg.sv
package acc_isa_pkg;

    // opcode sits above the 11-bit address field
    parameter int OPC_LSB = 11;
    parameter int OPC_W   = 5;
    parameter int ALU_W   = 4;

    // alu codes come first so bit 4 clear means alu op
    typedef enum logic [OPC_W-1:0] {
        OP_ADD, OP_SUB, OP_MUL, OP_DIV,
        OP_SHL, OP_SHR, OP_ROL, OP_ROR,
        OP_AND, OP_OR, OP_XOR, OP_NNOR,
        OP_NAND, OP_XNOR, OP_GT, OP_EQ,
        OP_LOAD, OP_STORE, OP_JUMP, OP_JZ,
        OP_OUT, OP_HALT
    } opcode_t;

    // low four bits of the alu opcodes
    typedef enum logic [ALU_W-1:0] {
        ALU_ADD, ALU_SUB, ALU_MUL, ALU_DIV,
        ALU_SHL, ALU_SHR, ALU_ROL, ALU_ROR,
        ALU_AND, ALU_OR, ALU_XOR, ALU_NNOR,
        ALU_NAND, ALU_XNOR, ALU_GT, ALU_EQ
    } alu_op_t;

endpackage

//--- logic/alu.sv
`timescale 1ns/1ps

module alu (
    input  acc_isa_pkg::alu_op_t op,
    input  acc_mem_pkg::word_t   operand1,
    input  acc_mem_pkg::word_t   operand2,
    output acc_mem_pkg::word_t   result
);
    import acc_mem_pkg::*;
    import acc_isa_pkg::*;

    // operand1 is always the accumulator
    always_comb begin
        case (op)
            ALU_ADD:  result = operand1 + operand2;
            ALU_SUB:  result = operand1 - operand2;
            // 16-bit context keeps the low half only
            ALU_MUL:  result = operand1 * operand2;
            // divide by zero saturates to all ones
            ALU_DIV:  result = (operand2 == '0) ? '1 : operand1 / operand2;
            ALU_SHL:  result = operand1 << 1;
            ALU_SHR:  result = operand1 >> 1;
            ALU_ROL:  result = {operand1[WORD_W-2:0], operand1[WORD_W-1]};
            ALU_ROR:  result = {operand1[0], operand1[WORD_W-1:1]};
            ALU_AND:  result = operand1 & operand2;
            ALU_OR:   result = operand1 | operand2;
            ALU_XOR:  result = operand1 ^ operand2;
            // nor negated twice, so plain or
            ALU_NNOR: result = ~(~(operand1 | operand2));
            ALU_NAND: result = ~(operand1 & operand2);
            ALU_XNOR: result = ~(operand1 ^ operand2);
            // unsigned compare, 1 or 0
            ALU_GT:   result = word_t'(operand1 > operand2);
            ALU_EQ:   result = word_t'(operand1 == operand2);
            default:  result = '0;
        endcase
    end

endmodule

//--- logic/main_memory.sv
`timescale 1ns/1ps

module main_memory #(
    parameter int unsigned MEM_DEPTH = 2048
) (
    input  logic               clk,
    input  logic               busy,
    input  acc_mem_pkg::addr_t addr,
    input  logic               we,
    input  acc_mem_pkg::word_t wdata,
    input  logic               load_we,
    input  acc_mem_pkg::addr_t load_addr,
    input  acc_mem_pkg::word_t load_data,
    output acc_mem_pkg::word_t rdata
);
    import acc_mem_pkg::*;

    word_t mem [MEM_DEPTH];

    // port select, load side owns memory while idle
    addr_t sel_addr;
    word_t sel_data;
    logic  sel_we;
    logic  in_range;

    always_comb begin
        sel_addr = busy ? addr : load_addr;
        sel_data = busy ? wdata : load_data;
        sel_we   = busy ? we : load_we;
    end

    // addresses past the end read zero and drop writes
    assign in_range = (32'(sel_addr) < MEM_DEPTH);

    // read-before-write, read also on write cycles
    always_ff @(posedge clk) begin
        if (sel_we && in_range) begin
            mem[sel_addr] <= sel_data;
        end
        rdata <= in_range ? mem[sel_addr] : '0;
    end

endmodule

//--- logic/control_unit.sv
`timescale 1ns/1ps

module control_unit (
    input  logic                 clk,
    input  logic                 rst_n,
    input  logic                 start,
    input  acc_mem_pkg::word_t   mem_rdata,
    input  logic                 acc_zero,
    input  logic                 out_credit_avail,
    output acc_mem_pkg::addr_t   mem_addr,
    output logic                 mem_we,
    output acc_isa_pkg::alu_op_t alu_op,
    output logic                 acc_load_mem,
    output logic                 acc_load_alu,
    output logic                 out_send,
    output logic                 busy
);
    import acc_mem_pkg::*;
    import acc_isa_pkg::*;

    typedef enum logic [2:0] {
        S_IDLE, S_FETCH, S_DECODE, S_EXEC, S_HALTED
    } state_t;

    state_t  state;
    addr_t   pc;
    word_t   ir;
    addr_t   mar;
    opcode_t opcode;
    logic    in_exec;

    assign opcode  = opcode_t'(ir[OPC_LSB +: OPC_W]);
    assign in_exec = (state == S_EXEC);

    // state and pc
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state <= S_IDLE;
            pc    <= '0;
        end else begin
            case (state)
                S_IDLE, S_HALTED: begin
                    if (start) begin
                        pc    <= '0;
                        state <= S_FETCH;
                    end
                end
                S_FETCH: state <= S_DECODE;
                S_DECODE: begin
                    // wraps at the top of the address space
                    pc    <= pc + 1'b1;
                    state <= S_EXEC;
                end
                S_EXEC: begin
                    state <= S_FETCH;
                    case (opcode)
                        OP_JUMP: pc <= mar;
                        OP_JZ: begin
                            if (acc_zero) begin
                                pc <= mar;
                            end
                        end
                        // stall here until a credit shows up
                        OP_OUT: begin
                            if (!out_credit_avail) begin
                                state <= S_EXEC;
                            end
                        end
                        OP_HALT: state <= S_HALTED;
                        default: ;
                    endcase
                end
                default: state <= S_IDLE;
            endcase
        end
    end

    // instruction word arrives from memory during decode
    always_ff @(posedge clk) begin
        if (state == S_DECODE) begin
            ir  <= mem_rdata;
            mar <= mem_rdata[ADDR_W-1:0];
        end
    end

    // pc on fetch, operand address from decode on
    always_comb begin
        case (state)
            S_DECODE: mem_addr = mem_rdata[ADDR_W-1:0];
            S_EXEC:   mem_addr = mar;
            default:  mem_addr = pc;
        endcase
    end

    assign busy         = (state == S_FETCH) || (state == S_DECODE) || in_exec;
    assign mem_we       = in_exec && (opcode == OP_STORE);
    // bit 4 clear selects the sixteen alu functions
    assign acc_load_alu = in_exec && !ir[OPC_LSB + OPC_W - 1];
    assign acc_load_mem = in_exec && (opcode == OP_LOAD);
    assign out_send     = in_exec && (opcode == OP_OUT) && out_credit_avail;
    assign alu_op       = alu_op_t'(ir[OPC_LSB +: ALU_W]);

endmodule

//--- logic/acc_datapath.sv
`timescale 1ns/1ps

module acc_datapath (
    input  logic                 clk,
    input  logic                 rst_n,
    input  acc_mem_pkg::word_t   mem_rdata,
    input  acc_isa_pkg::alu_op_t alu_op,
    input  logic                 acc_load_mem,
    input  logic                 acc_load_alu,
    output acc_mem_pkg::word_t   acc,
    output logic                 acc_zero
);
    import acc_mem_pkg::*;
    import acc_isa_pkg::*;

    word_t   mbr;
    word_t   alu_result;
    alu_op_t wb_op;
    logic    wb_mem;
    logic    wb_alu;

    // operand word lands in mbr the cycle after exec
    always_ff @(posedge clk) begin
        mbr   <= mem_rdata;
        wb_op <= alu_op;
    end

    alu u_alu (
        .op       (wb_op),
        .operand1 (acc),
        .operand2 (mbr),
        .result   (alu_result)
    );

    // strobes delayed one cycle to line up with mbr
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wb_mem <= 1'b0;
            wb_alu <= 1'b0;
            acc    <= '0;
        end else begin
            wb_mem <= acc_load_mem;
            wb_alu <= acc_load_alu;
            if (wb_mem) begin
                acc <= mbr;
            end else if (wb_alu) begin
                acc <= alu_result;
            end
        end
    end

    // jz condition
    assign acc_zero = (acc == '0);

endmodule

//--- logic/out_credit_port.sv
`timescale 1ns/1ps

module out_credit_port #(
    parameter int unsigned OUT_CREDITS = 2
) (
    input  logic               clk,
    input  logic               rst_n,
    input  logic               send,
    input  acc_mem_pkg::word_t acc,
    input  logic               credit_return,
    output logic               credit_avail,
    output logic               out_valid,
    output acc_mem_pkg::word_t out_data
);
    localparam int CNT_W = $clog2(OUT_CREDITS + 1);

    logic [CNT_W-1:0] credits;
    logic             take;

    // guard against a send with no credit left
    assign take         = send && credit_avail;
    assign credit_avail = (credits != '0);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            credits   <= CNT_W'(OUT_CREDITS);
            out_valid <= 1'b0;
        end else begin
            out_valid <= take;
            // simultaneous take and return cancel out
            if (take && !credit_return) begin
                credits <= credits - 1'b1;
            end else if (credit_return && !take && credits != CNT_W'(OUT_CREDITS)) begin
                credits <= credits + 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (take) begin
            out_data <= acc;
        end
    end

endmodule

//--- logic/acc_cpu_top.sv
`timescale 1ns/1ps

module acc_cpu_top #(
    parameter int unsigned MEM_DEPTH   = 2048,
    parameter int unsigned OUT_CREDITS = 2
) (
    input  logic               clk,
    input  logic               rst_n,
    input  logic               load_we,
    input  acc_mem_pkg::addr_t load_addr,
    input  acc_mem_pkg::word_t load_data,
    input  logic               start,
    input  logic               credit_return,
    output logic               busy,
    output logic               out_valid,
    output acc_mem_pkg::word_t out_data
);
    import acc_mem_pkg::*;
    import acc_isa_pkg::*;

    addr_t   mem_addr;
    logic    mem_we;
    word_t   mem_rdata;
    word_t   acc;
    logic    acc_zero;
    alu_op_t alu_op;
    logic    acc_load_mem;
    logic    acc_load_alu;
    logic    out_send;
    logic    out_credit_avail;

    control_unit u_control_unit (
        .clk              (clk),
        .rst_n            (rst_n),
        .start            (start),
        .mem_rdata        (mem_rdata),
        .acc_zero         (acc_zero),
        .out_credit_avail (out_credit_avail),
        .mem_addr         (mem_addr),
        .mem_we           (mem_we),
        .alu_op           (alu_op),
        .acc_load_mem     (acc_load_mem),
        .acc_load_alu     (acc_load_alu),
        .out_send         (out_send),
        .busy             (busy)
    );

    acc_datapath u_acc_datapath (
        .clk          (clk),
        .rst_n        (rst_n),
        .mem_rdata    (mem_rdata),
        .alu_op       (alu_op),
        .acc_load_mem (acc_load_mem),
        .acc_load_alu (acc_load_alu),
        .acc          (acc),
        .acc_zero     (acc_zero)
    );

    // store data is the accumulator
    main_memory #(
        .MEM_DEPTH (MEM_DEPTH)
    ) u_main_memory (
        .clk       (clk),
        .busy      (busy),
        .addr      (mem_addr),
        .we        (mem_we),
        .wdata     (acc),
        .load_we   (load_we),
        .load_addr (load_addr),
        .load_data (load_data),
        .rdata     (mem_rdata)
    );

    out_credit_port #(
        .OUT_CREDITS (OUT_CREDITS)
    ) u_out_credit_port (
        .clk           (clk),
        .rst_n         (rst_n),
        .send          (out_send),
        .acc           (acc),
        .credit_return (credit_return),
        .credit_avail  (out_credit_avail),
        .out_valid     (out_valid),
        .out_data      (out_data)
    );

endmodule

//--- tb/tb_acc_cpu_top.sv
`timescale 1ns/1ps

module tb_acc_cpu_top;
    import acc_mem_pkg::*;
    import acc_isa_pkg::*;

    parameter int unsigned SEED = 73458;

    localparam int unsigned OUT_CREDITS = 2;
    localparam int N_RAND    = 32;
    localparam int RUN_LIMIT = 400;

    logic  clk;
    logic  rst_n;
    logic  load_we;
    addr_t load_addr;
    word_t load_data;
    logic  start;
    logic  credit_return;
    logic  busy;
    logic  out_valid;
    word_t out_data;

    // alu table rows
    alu_op_t tab_op[$];
    word_t   tab_a[$];
    word_t   tab_b[$];
    word_t   tab_exp[$];

    // program image, expected and observed output words
    word_t prog[$];
    word_t exp_q[$];
    word_t seen_q[$];
    int    pending;
    logic  hold_credits;

    acc_cpu_top #(
        .MEM_DEPTH   (2048),
        .OUT_CREDITS (OUT_CREDITS)
    ) u_acc_cpu_top (.*);

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    // consumer model, one credit back per word unless holding
    initial begin
        credit_return = 1'b0;
        pending       = 0;
        forever begin
            // out_valid is settled mid cycle
            @(negedge clk);
            if (out_valid) begin
                seen_q.push_back(out_data);
                pending++;
            end
            @(posedge clk);
            #1;
            credit_return = !hold_credits && (pending > 0);
            if (credit_return) begin
                pending--;
            end
        end
    end

    task automatic stop_run(input string why);
        $display("%s", why);
        $display("Test failures found");
        $fatal(1);
    endtask

    task automatic check_word(input string name, input word_t exp, input word_t act);
        if (act !== exp) begin
            $display("ERR %0t %s expected %h actual %h", $time, name, exp, act);
            $display("Test failures found");
            $fatal(1);
        end
    endtask

    task automatic check_bit(input string name, input logic exp, input logic act);
        if (act !== exp) begin
            $display("ERR %0t %s expected %b actual %b", $time, name, exp, act);
            $display("Test failures found");
            $fatal(1);
        end
    endtask

    task automatic next_cycle();
        @(posedge clk);
        #1;
    endtask

    // opcode in the top five bits, address below
    function automatic word_t instr(input opcode_t opc, input addr_t adr);
        return (word_t'(opc) << OPC_LSB) | word_t'(adr);
    endfunction

    // expected alu result straight from the function list
    function automatic word_t alu_model(input alu_op_t op, input word_t a, input word_t b);
        logic [31:0] prod;
        word_t       r;
        prod = 32'(a) * 32'(b);
        case (op)
            ALU_ADD:  r = a + b;
            ALU_SUB:  r = a - b;
            ALU_MUL:  r = prod[15:0];
            ALU_DIV:  r = (b == 16'h0000) ? 16'hffff : a / b;
            ALU_SHL:  r = {a[14:0], 1'b0};
            ALU_SHR:  r = {1'b0, a[15:1]};
            ALU_ROL:  r = (a << 1) | (a >> 15);
            ALU_ROR:  r = (a >> 1) | (a << 15);
            ALU_AND:  r = a & b;
            ALU_OR:   r = a | b;
            ALU_XOR:  r = a ^ b;
            ALU_NNOR: r = a | b;
            ALU_NAND: r = ~(a & b);
            ALU_XNOR: r = ~(a ^ b);
            ALU_GT:   r = (a > b) ? 16'd1 : 16'd0;
            default:  r = (a == b) ? 16'd1 : 16'd0;
        endcase
        return r;
    endfunction

    task automatic add_row(input alu_op_t op, input word_t a, input word_t b, input word_t e);
        tab_op.push_back(op);
        tab_a.push_back(a);
        tab_b.push_back(b);
        tab_exp.push_back(e);
    endtask

    task automatic build_table();
        alu_op_t op;
        word_t   a;
        word_t   b;
        // corners, worked by hand
        add_row(ALU_ADD, 16'hffff, 16'h0002, 16'h0001);
        add_row(ALU_SUB, 16'h0000, 16'h0001, 16'hffff);
        add_row(ALU_MUL, 16'h1234, 16'h0010, 16'h2340);
        add_row(ALU_DIV, 16'h1234, 16'h0000, 16'hffff);
        add_row(ALU_DIV, 16'h0064, 16'h0007, 16'h000e);
        add_row(ALU_ROL, 16'h8001, 16'h0000, 16'h0003);
        add_row(ALU_ROR, 16'h0001, 16'h0000, 16'h8000);
        add_row(ALU_NNOR, 16'h00f0, 16'h0f00, 16'h0ff0);
        add_row(ALU_GT, 16'h0001, 16'hffff, 16'h0000);
        add_row(ALU_EQ, 16'ha5a5, 16'ha5a5, 16'h0001);
        // random rows sweep all sixteen functions twice
        for (int i = 0; i < N_RAND; i++) begin
            op = alu_op_t'(i % 16);
            a  = word_t'($urandom);
            b  = word_t'($urandom);
            add_row(op, a, b, alu_model(op, a, b));
        end
    endtask

    task automatic load_word(input addr_t adr, input word_t data);
        load_we   = 1'b1;
        load_addr = adr;
        load_data = data;
        next_cycle();
        load_we   = 1'b0;
    endtask

    task automatic load_prog();
        foreach (prog[i]) load_word(addr_t'(i), prog[i]);
    endtask

    task automatic start_program();
        seen_q.delete();
        start = 1'b1;
        next_cycle();
        start = 1'b0;
        check_bit("busy", 1'b1, busy);
    endtask

    task automatic wait_idle();
        int n;
        n = 0;
        while (busy) begin
            if (n == RUN_LIMIT) begin
                stop_run("timeout waiting for busy to fall");
            end else begin
                next_cycle();
                n++;
            end
        end
    endtask

    task automatic run_program();
        start_program();
        wait_idle();
    endtask

    task automatic check_outputs();
        if (seen_q.size() != exp_q.size()) begin
            stop_run($sformatf("expected %0d output words but saw %0d",
                               exp_q.size(), seen_q.size()));
        end else begin
            foreach (exp_q[i]) check_word("out_data", exp_q[i], seen_q[i]);
        end
    endtask

    // load a, apply the op with b, send, halt
    task automatic run_alu_row(input int i);
        prog = '{instr(OP_LOAD, 11'd16), instr(opcode_t'({1'b0, tab_op[i]}), 11'd17),
                 instr(OP_OUT, 11'd0), instr(OP_HALT, 11'd0)};
        load_prog();
        load_word(11'd16, tab_a[i]);
        load_word(11'd17, tab_b[i]);
        exp_q = '{tab_exp[i]};
        run_program();
        check_outputs();
    endtask

    task automatic mem_branch_test();
        load_word(11'd100, 16'h0000);
        load_word(11'd101, 16'h1234);
        load_word(11'd102, 16'h00a1);
        load_word(11'd103, 16'h00b2);
        load_word(11'd104, 16'hdead);
        load_word(11'd105, 16'h0c3d);
        // store and reload, jz not taken, jz taken, jump past an out, a no-op code
        prog = '{instr(OP_LOAD, 11'd101), instr(OP_STORE, 11'd104),
                 instr(OP_LOAD, 11'd100), instr(OP_LOAD, 11'd104),
                 instr(OP_OUT, 11'd0), instr(OP_JZ, 11'd8),
                 instr(OP_LOAD, 11'd102), instr(OP_OUT, 11'd0),
                 instr(OP_LOAD, 11'd100), instr(OP_JZ, 11'd11),
                 instr(OP_OUT, 11'd0), instr(OP_LOAD, 11'd103),
                 instr(OP_OUT, 11'd0), instr(OP_JUMP, 11'd15),
                 instr(OP_OUT, 11'd0), word_t'(22 << OPC_LSB),
                 instr(OP_LOAD, 11'd105), instr(OP_OUT, 11'd0),
                 instr(OP_HALT, 11'd0)};
        load_prog();
        exp_q = '{16'h1234, 16'h00a1, 16'h00b2, 16'h0c3d};
        run_program();
        check_outputs();
    endtask

    task automatic credit_test();
        prog.delete();
        exp_q.delete();
        for (int k = 0; k < 5; k++) begin
            load_word(addr_t'(200 + k), word_t'(16'h5a00 + k));
            prog.push_back(instr(OP_LOAD, addr_t'(200 + k)));
            prog.push_back(instr(OP_OUT, 11'd0));
            exp_q.push_back(word_t'(16'h5a00 + k));
        end
        prog.push_back(instr(OP_HALT, 11'd0));
        load_prog();
        hold_credits = 1'b1;
        start_program();
        // out stalls once the credits run dry
        repeat (40) begin
            check_bit("busy", 1'b1, busy);
            next_cycle();
        end
        if (seen_q.size() > OUT_CREDITS) begin
            stop_run($sformatf("%0d words sent while credits were held", seen_q.size()));
        end
        hold_credits = 1'b0;
        wait_idle();
        check_outputs();
    endtask

    task automatic restart_test();
        // halted machine stays quiet
        repeat (10) begin
            check_bit("busy", 1'b0, busy);
            check_bit("out_valid", 1'b0, out_valid);
            next_cycle();
        end
        load_word(11'd300, 16'h0f0f);
        load_word(11'd301, 16'h1001);
        prog = '{instr(OP_LOAD, 11'd300), instr(OP_OUT, 11'd0), instr(OP_SUB, 11'd301),
                 instr(OP_OUT, 11'd0), instr(OP_HALT, 11'd0)};
        load_prog();
        exp_q = '{16'h0f0f, 16'hff0e};
        run_program();
        check_outputs();
    endtask

    initial begin
        rst_n        = 1'b0;
        load_we      = 1'b0;
        load_addr    = '0;
        load_data    = '0;
        start        = 1'b0;
        hold_credits = 1'b0;
        void'($urandom(SEED));
        repeat (3) @(posedge clk);
        #1;
        rst_n = 1'b1;
        // idle after reset, nothing moves without start
        repeat (10) begin
            check_bit("busy", 1'b0, busy);
            check_bit("out_valid", 1'b0, out_valid);
            next_cycle();
        end
        build_table();
        foreach (tab_op[i]) run_alu_row(i);
        mem_branch_test();
        credit_test();
        restart_test();
        $display("All tests passed!");
        $finish;
    end

endmodule

//--- list.f
logic/acc_mem_pkg.sv
logic/acc_isa_pkg.sv
logic/alu.sv
logic/main_memory.sv
logic/control_unit.sv
logic/acc_datapath.sv
logic/out_credit_port.sv
logic/acc_cpu_top.sv
tb/tb_acc_cpu_top.sv

//--- Makefile
# Verilator flow for the accumulator CPU testbench
TOP        ?= tb_acc_cpu_top
SEED       ?= 73458
VERILATOR  ?= verilator
FILELIST   ?= list.f
OBJ_DIR    ?= obj_dir
LINT_FLAGS ?= --lint-only -Wall --timing
SIM_FLAGS  ?= --binary --timing -Wno-fatal

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) -f $(FILELIST) --top-module $(TOP) -GSEED=$(SEED)

# the run's exit status is the pass or fail result
sim:
	$(VERILATOR) $(SIM_FLAGS) -f $(FILELIST) --top-module $(TOP) -GSEED=$(SEED) \
		--Mdir $(OBJ_DIR) -o V$(TOP)
	./$(OBJ_DIR)/V$(TOP)

clean:
	rm -rf $(OBJ_DIR)
